// File: source/soc_mem_map_pkg.sv
// Memory map windows of the L2 interconnect, shared by the address decoder and the testbench

package soc_mem_map_pkg;

    //////////////////////////////////////////////////////////
    // Interleaved L2 region
    //////////////////////////////////////////////////////////

    // Main interleaved window, 8 KiB spread over all banks
    localparam logic [31:0] L2_INTLVD_START = 32'h1C01_0000;
    localparam logic [31:0] L2_INTLVD_END   = 32'h1C01_1FFF;

    // Alias of the interleaved storage
    // Same offset inside the window reaches the same word
    localparam logic [31:0] L2_ALIAS_START  = 32'h1001_0000;
    localparam logic [31:0] L2_ALIAS_END    = 32'h1001_1FFF;

    //////////////////////////////////////////////////////////
    // Private bank
    //////////////////////////////////////////////////////////

    // Contiguous 4 KiB bank, not interleaved
    localparam logic [31:0] L2_PRIV_START   = 32'h1C00_0000;
    localparam logic [31:0] L2_PRIV_END     = 32'h1C00_0FFF;

    // Anything outside these three windows is unmapped

endpackage

// File: source/l2_xbar_pkg.sv
// Bus widths, bank geometry and routed request types used across the L2 interconnect

package l2_xbar_pkg;

    //////////////////////////////////////////////////////////
    // Master side bus
    //////////////////////////////////////////////////////////

    // Byte address and data word
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    // One enable per data byte
    typedef logic [3:0]  be_t;

    // FC data port and DMA port
    localparam int NUM_MASTERS = 2;
    typedef logic [0:0]  master_id_t;

    //////////////////////////////////////////////////////////
    // Bank geometry
    //////////////////////////////////////////////////////////

    // Word interleaving over four banks
    localparam int NUM_BANKS   = 4;
    typedef logic [1:0]  bank_idx_t;

    // Rows per interleaved bank, words in the private bank
    localparam int INTLVD_ROWS = 512;
    localparam int PRIV_WORDS  = 1024;

    // Wide enough for the private bank, interleaved rows use the low bits
    typedef logic [9:0]  word_idx_t;

    // Entries between arbiter and bank array
    localparam int FIFO_DEPTH  = 4;

    // Target of a decoded request
    typedef enum logic [1:0] {
        REGION_INTLVD = 2'd0,
        REGION_PRIV   = 2'd1,
        REGION_NONE   = 2'd2
    } region_e;

endpackage

// File: source/l2_req_arbiter.sv
// Round-robin master arbiter and address decoder that feeds the L2 request FIFO

module l2_req_arbiter (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    // Master request ports
    input  logic                   req_valid_i [l2_xbar_pkg::NUM_MASTERS],
    input  l2_xbar_pkg::addr_t     req_addr_i  [l2_xbar_pkg::NUM_MASTERS],
    input  logic                   req_we_i    [l2_xbar_pkg::NUM_MASTERS],
    input  l2_xbar_pkg::be_t       req_be_i    [l2_xbar_pkg::NUM_MASTERS],
    input  l2_xbar_pkg::data_t     req_wdata_i [l2_xbar_pkg::NUM_MASTERS],
    output logic                   req_ready_o [l2_xbar_pkg::NUM_MASTERS],
    // Routed request towards the FIFO
    output logic                   out_valid_o,
    input  logic                   out_ready_i,
    output l2_xbar_pkg::region_e   out_region_o,
    output l2_xbar_pkg::bank_idx_t out_bank_o,
    output l2_xbar_pkg::word_idx_t out_row_o,
    output l2_xbar_pkg::master_id_t out_master_o,
    output logic                   out_we_o,
    output l2_xbar_pkg::be_t       out_be_o,
    output l2_xbar_pkg::data_t     out_wdata_o
);
    import l2_xbar_pkg::*;
    import soc_mem_map_pkg::*;

    // Master with the highest priority this cycle
    master_id_t rr_ptr_q;
    master_id_t rr_ptr_d;
    master_id_t grant_id;
    logic       grant_valid;
    logic [NUM_MASTERS-1:0] ready_vec;

    addr_t      sel_addr;
    addr_t      word_idx;
    region_e    region;

    ////////////////////////////////////////////////////////////
    // Grant selection
    ////////////////////////////////////////////////////////////

    always_comb begin
        master_id_t cand;
        grant_valid = 1'b0;
        grant_id    = rr_ptr_q;
        // Scan starting at the pointer, first requester wins
        for (int i = 0; i < NUM_MASTERS; i++) begin
            cand = master_id_t'((int'(rr_ptr_q) + i) % NUM_MASTERS);
            if (!grant_valid && req_valid_i[cand]) begin
                grant_valid = 1'b1;
                grant_id    = cand;
            end
        end
    end

    // Ready only towards the winner, and only with FIFO space
    always_comb begin
        for (int m = 0; m < NUM_MASTERS; m++) begin
            ready_vec[m]   = grant_valid && (grant_id == master_id_t'(m)) && out_ready_i;
            req_ready_o[m] = ready_vec[m];
        end
    end

    // Pointer steps past a master only once its request is taken
    assign rr_ptr_d = (grant_valid && out_ready_i) ?
                      master_id_t'((int'(grant_id) + 1) % NUM_MASTERS) : rr_ptr_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rr_ptr_q <= '0;
        end else begin
            rr_ptr_q <= rr_ptr_d;
        end
    end

    ////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////

    assign sel_addr = req_addr_i[grant_id];

    always_comb begin
        region   = REGION_NONE;
        word_idx = '0;
        if (sel_addr >= L2_INTLVD_START && sel_addr <= L2_INTLVD_END) begin
            region   = REGION_INTLVD;
            word_idx = (sel_addr - L2_INTLVD_START) >> $clog2($bits(be_t));
        end else if (sel_addr >= L2_ALIAS_START && sel_addr <= L2_ALIAS_END) begin
            // Alias folds onto the interleaved storage
            region   = REGION_INTLVD;
            word_idx = (sel_addr - L2_ALIAS_START) >> $clog2($bits(be_t));
        end else if (sel_addr >= L2_PRIV_START && sel_addr <= L2_PRIV_END) begin
            region   = REGION_PRIV;
            word_idx = (sel_addr - L2_PRIV_START) >> $clog2($bits(be_t));
        end
    end

    // Low word bits pick the bank, the rest the row
    assign out_bank_o   = (region == REGION_INTLVD) ? bank_idx_t'(word_idx % NUM_BANKS) : '0;
    assign out_row_o    = (region == REGION_INTLVD) ? word_idx_t'(word_idx / NUM_BANKS) :
                                                      word_idx_t'(word_idx);
    assign out_region_o = region;

    // Payload of the granted master
    assign out_valid_o  = grant_valid;
    assign out_master_o = grant_id;
    assign out_we_o     = req_we_i[grant_id];
    assign out_be_o     = req_be_i[grant_id];
    assign out_wdata_o  = req_wdata_i[grant_id];

    // Only one master may see its request accepted per cycle
    a_one_ready : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $onehot0(ready_vec));

endmodule

// File: source/l2_req_fifo.sv
// Request FIFO that decouples arbitration from the bank array access

module l2_req_fifo (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    // Push side
    input  logic                    in_valid_i,
    output logic                    in_ready_o,
    input  l2_xbar_pkg::region_e    in_region_i,
    input  l2_xbar_pkg::bank_idx_t  in_bank_i,
    input  l2_xbar_pkg::word_idx_t  in_row_i,
    input  l2_xbar_pkg::master_id_t in_master_i,
    input  logic                    in_we_i,
    input  l2_xbar_pkg::be_t        in_be_i,
    input  l2_xbar_pkg::data_t      in_wdata_i,
    // Pop side
    output logic                    out_valid_o,
    input  logic                    out_ready_i,
    output l2_xbar_pkg::region_e    out_region_o,
    output l2_xbar_pkg::bank_idx_t  out_bank_o,
    output l2_xbar_pkg::word_idx_t  out_row_o,
    output l2_xbar_pkg::master_id_t out_master_o,
    output logic                    out_we_o,
    output l2_xbar_pkg::be_t        out_be_o,
    output l2_xbar_pkg::data_t      out_wdata_o
);
    import l2_xbar_pkg::*;

    // Entry storage, one array per field
    region_e    region_mem [FIFO_DEPTH];
    bank_idx_t  bank_mem   [FIFO_DEPTH];
    word_idx_t  row_mem    [FIFO_DEPTH];
    master_id_t master_mem [FIFO_DEPTH];
    logic       we_mem     [FIFO_DEPTH];
    be_t        be_mem     [FIFO_DEPTH];
    data_t      wdata_mem  [FIFO_DEPTH];

    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr_q;
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr_q;
    logic [$clog2(FIFO_DEPTH):0]   count_q;
    logic push;
    logic pop;

    assign in_ready_o  = (count_q != FIFO_DEPTH);
    assign out_valid_o = (count_q != 0);
    assign push        = in_valid_i && in_ready_o;
    assign pop         = out_valid_o && out_ready_i;

    ////////////////////////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == FIFO_DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == FIFO_DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop leave the count alone
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Entry write
    always_ff @(posedge clk_i) begin
        if (push) begin
            region_mem[wr_ptr_q] <= in_region_i;
            bank_mem[wr_ptr_q]   <= in_bank_i;
            row_mem[wr_ptr_q]    <= in_row_i;
            master_mem[wr_ptr_q] <= in_master_i;
            we_mem[wr_ptr_q]     <= in_we_i;
            be_mem[wr_ptr_q]     <= in_be_i;
            wdata_mem[wr_ptr_q]  <= in_wdata_i;
        end
    end

    // Head entry
    assign out_region_o = region_mem[rd_ptr_q];
    assign out_bank_o   = bank_mem[rd_ptr_q];
    assign out_row_o    = row_mem[rd_ptr_q];
    assign out_master_o = master_mem[rd_ptr_q];
    assign out_we_o     = we_mem[rd_ptr_q];
    assign out_be_o     = be_mem[rd_ptr_q];
    assign out_wdata_o  = wdata_mem[rd_ptr_q];

    // Full FIFO with a stalled consumer never overflows into a wrapped count
    a_no_push_full : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (count_q == FIFO_DEPTH && !out_ready_i) |=> count_q == FIFO_DEPTH);

    // Empty FIFO without a producer never underflows
    a_no_pop_empty : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (count_q == 0 && !in_valid_i) |=> count_q == 0);

endmodule

// File: source/l2_bank_array.sv
// Interleaved and private L2 banks with the registered response back to the masters

module l2_bank_array (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    // Routed request from the FIFO
    input  logic                    in_valid_i,
    output logic                    in_ready_o,
    input  l2_xbar_pkg::region_e    in_region_i,
    input  l2_xbar_pkg::bank_idx_t  in_bank_i,
    input  l2_xbar_pkg::word_idx_t  in_row_i,
    input  l2_xbar_pkg::master_id_t in_master_i,
    input  logic                    in_we_i,
    input  l2_xbar_pkg::be_t        in_be_i,
    input  l2_xbar_pkg::data_t      in_wdata_i,
    // Response ports, one per master
    output logic                    rsp_valid_o [l2_xbar_pkg::NUM_MASTERS],
    input  logic                    rsp_ready_i [l2_xbar_pkg::NUM_MASTERS],
    output l2_xbar_pkg::data_t      rsp_rdata_o [l2_xbar_pkg::NUM_MASTERS],
    output logic                    rsp_err_o   [l2_xbar_pkg::NUM_MASTERS]
);
    import l2_xbar_pkg::*;

    // Storage
    data_t intlvd_mem [NUM_BANKS][INTLVD_ROWS];
    data_t priv_mem   [PRIV_WORDS];

    // Response register
    logic       rsp_valid_q;
    master_id_t rsp_master_q;
    data_t      rsp_rdata_q;
    logic       rsp_err_q;

    logic  pop;
    data_t rd_word;
    logic [$clog2(INTLVD_ROWS)-1:0] intlvd_row;

    // Accept when the slot is free or drains this cycle
    assign in_ready_o = !rsp_valid_q || rsp_ready_i[rsp_master_q];
    assign pop        = in_valid_i && in_ready_o;
    assign intlvd_row = in_row_i[$clog2(INTLVD_ROWS)-1:0];

    ////////////////////////////////////////////////////////////
    // Memory access
    ////////////////////////////////////////////////////////////

    // Byte-enabled write, unmapped requests touch nothing
    always_ff @(posedge clk_i) begin
        if (pop && in_we_i) begin
            for (int b = 0; b < $bits(be_t); b++) begin
                if (in_be_i[b]) begin
                    if (in_region_i == REGION_INTLVD) begin
                        intlvd_mem[in_bank_i][intlvd_row][8*b +: 8] <= in_wdata_i[8*b +: 8];
                    end else if (in_region_i == REGION_PRIV) begin
                        priv_mem[in_row_i][8*b +: 8] <= in_wdata_i[8*b +: 8];
                    end
                end
            end
        end
    end

    // Read word, zero for unmapped
    always_comb begin
        case (in_region_i)
            REGION_INTLVD: rd_word = intlvd_mem[in_bank_i][intlvd_row];
            REGION_PRIV:   rd_word = priv_mem[in_row_i];
            default:       rd_word = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Response
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else if (pop) begin
            rsp_valid_q <= 1'b1;
        end else if (rsp_valid_q && rsp_ready_i[rsp_master_q]) begin
            rsp_valid_q <= 1'b0;
        end
    end

    // Payload is only loaded on pop
    always_ff @(posedge clk_i) begin
        if (pop) begin
            rsp_master_q <= in_master_i;
            rsp_err_q    <= (in_region_i == REGION_NONE);
            // Writes answer with zero data
            rsp_rdata_q  <= in_we_i ? '0 : rd_word;
        end
    end

    // Valid goes to the owner only, payload is shared
    always_comb begin
        for (int m = 0; m < NUM_MASTERS; m++) begin
            rsp_valid_o[m] = rsp_valid_q && (rsp_master_q == master_id_t'(m));
            rsp_rdata_o[m] = rsp_rdata_q;
            rsp_err_o[m]   = rsp_err_q;
        end
    end

    // Held response must not change under back-pressure
    a_rsp_stable : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (rsp_valid_q && !rsp_ready_i[rsp_master_q]) |=>
        (rsp_valid_q && $stable(rsp_master_q) && $stable(rsp_rdata_q) && $stable(rsp_err_q)));

endmodule

// File: source/soc_l2_interconnect.sv
// Top level of the L2 interconnect joining arbiter, request FIFO and bank array

module soc_l2_interconnect (
    input  logic               clk_i,
    input  logic               arst_n_i,
    // Master requests
    input  logic               req_valid_i [l2_xbar_pkg::NUM_MASTERS],
    input  l2_xbar_pkg::addr_t req_addr_i  [l2_xbar_pkg::NUM_MASTERS],
    input  logic               req_we_i    [l2_xbar_pkg::NUM_MASTERS],
    input  l2_xbar_pkg::be_t   req_be_i    [l2_xbar_pkg::NUM_MASTERS],
    input  l2_xbar_pkg::data_t req_wdata_i [l2_xbar_pkg::NUM_MASTERS],
    output logic               req_ready_o [l2_xbar_pkg::NUM_MASTERS],
    // Master responses
    output logic               rsp_valid_o [l2_xbar_pkg::NUM_MASTERS],
    input  logic               rsp_ready_i [l2_xbar_pkg::NUM_MASTERS],
    output l2_xbar_pkg::data_t rsp_rdata_o [l2_xbar_pkg::NUM_MASTERS],
    output logic               rsp_err_o   [l2_xbar_pkg::NUM_MASTERS]
);
    import l2_xbar_pkg::*;

    ////////////////////////////////////////////////////////////
    // Arbiter to FIFO
    ////////////////////////////////////////////////////////////

    logic       arb_valid;
    logic       arb_ready;
    region_e    arb_region;
    bank_idx_t  arb_bank;
    word_idx_t  arb_row;
    master_id_t arb_master;
    logic       arb_we;
    be_t        arb_be;
    data_t      arb_wdata;

    // FIFO to bank array
    logic       fifo_valid;
    logic       fifo_ready;
    region_e    fifo_region;
    bank_idx_t  fifo_bank;
    word_idx_t  fifo_row;
    master_id_t fifo_master;
    logic       fifo_we;
    be_t        fifo_be;
    data_t      fifo_wdata;

    l2_req_arbiter i_arbiter (
        .clk_i,
        .arst_n_i,
        .req_valid_i,
        .req_addr_i,
        .req_we_i,
        .req_be_i,
        .req_wdata_i,
        .req_ready_o,
        .out_valid_o  (arb_valid),
        .out_ready_i  (arb_ready),
        .out_region_o (arb_region),
        .out_bank_o   (arb_bank),
        .out_row_o    (arb_row),
        .out_master_o (arb_master),
        .out_we_o     (arb_we),
        .out_be_o     (arb_be),
        .out_wdata_o  (arb_wdata)
    );

    l2_req_fifo i_req_fifo (
        .clk_i,
        .arst_n_i,
        .in_valid_i   (arb_valid),
        .in_ready_o   (arb_ready),
        .in_region_i  (arb_region),
        .in_bank_i    (arb_bank),
        .in_row_i     (arb_row),
        .in_master_i  (arb_master),
        .in_we_i      (arb_we),
        .in_be_i      (arb_be),
        .in_wdata_i   (arb_wdata),
        .out_valid_o  (fifo_valid),
        .out_ready_i  (fifo_ready),
        .out_region_o (fifo_region),
        .out_bank_o   (fifo_bank),
        .out_row_o    (fifo_row),
        .out_master_o (fifo_master),
        .out_we_o     (fifo_we),
        .out_be_o     (fifo_be),
        .out_wdata_o  (fifo_wdata)
    );

    // Banks and response steering
    l2_bank_array i_bank_array (
        .clk_i,
        .arst_n_i,
        .in_valid_i  (fifo_valid),
        .in_ready_o  (fifo_ready),
        .in_region_i (fifo_region),
        .in_bank_i   (fifo_bank),
        .in_row_i    (fifo_row),
        .in_master_i (fifo_master),
        .in_we_i     (fifo_we),
        .in_be_i     (fifo_be),
        .in_wdata_i  (fifo_wdata),
        .rsp_valid_o,
        .rsp_ready_i,
        .rsp_rdata_o,
        .rsp_err_o
    );

endmodule

// File: test/tb_soc_l2_interconnect.sv
// Random-stimulus testbench for the L2 interconnect, run as top module against a reference memory model

module tb_soc_l2_interconnect;
    import l2_xbar_pkg::*;
    import soc_mem_map_pkg::*;

    localparam int          CLK_PERIOD    = 8;
    localparam logic [31:0] SEED          = 32'hfee4c0cb;
    localparam int          POOL_WORDS    = 32;
    localparam int          N_RANDOM      = 300;
    localparam int          N_SATURATE    = 200;
    localparam int          TOTAL_REQS    = NUM_MASTERS * (POOL_WORDS + N_RANDOM + N_SATURATE);
    localparam int          INTLVD_WORDS  = NUM_BANKS * INTLVD_ROWS;
    // Driver modes
    localparam int          MODE_PRELOAD  = 0;
    localparam int          MODE_RANDOM   = 1;
    localparam int          MODE_SATURATE = 2;

    logic  clk_i = 1'b0;
    logic  arst_n_i;
    logic  req_valid_i [NUM_MASTERS];
    addr_t req_addr_i  [NUM_MASTERS];
    logic  req_we_i    [NUM_MASTERS];
    be_t   req_be_i    [NUM_MASTERS];
    data_t req_wdata_i [NUM_MASTERS];
    logic  req_ready_o [NUM_MASTERS];
    logic  rsp_valid_o [NUM_MASTERS];
    logic  rsp_ready_i [NUM_MASTERS];
    data_t rsp_rdata_o [NUM_MASTERS];
    logic  rsp_err_o   [NUM_MASTERS];

    // Reference memory, interleaved words first, private words after them
    data_t model_mem [INTLVD_WORDS + PRIV_WORDS];
    // Expected responses per master, in issue order
    data_t exp_rdata [NUM_MASTERS][$];
    bit    exp_err   [NUM_MASTERS][$];
    // Response back-pressure pattern
    logic [31:0] rdy_rng   [NUM_MASTERS];
    int          stall_len [NUM_MASTERS];
    logic        stall_en;

    soc_l2_interconnect uut (
        .clk_i,
        .arst_n_i,
        .req_valid_i,
        .req_addr_i,
        .req_we_i,
        .req_be_i,
        .req_wdata_i,
        .req_ready_o,
        .rsp_valid_o,
        .rsp_ready_i,
        .rsp_rdata_o,
        .rsp_err_o
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Word locations 0..31 of each window, plus a few unmapped spots around them
    function automatic addr_t pick_addr(input logic [31:0] r);
        addr_t off;
        off = addr_t'(r[8:4]) << 2;
        case (r[2:0])
            3'd0, 3'd1, 3'd2: return L2_INTLVD_START + off;
            3'd3, 3'd4:       return L2_ALIAS_START + off;
            3'd5, 3'd6:       return L2_PRIV_START + off;
            default: begin
                case (r[10:9])
                    2'd0:    return L2_INTLVD_END + 32'd1 + off;
                    2'd1:    return L2_PRIV_END + 32'd1 + off;
                    2'd2:    return L2_ALIAS_START - 32'd4 - off;
                    default: return off;
                endcase
            end
        endcase
    endfunction

    // Model location of an address, -1 when unmapped
    function automatic int decode_loc(input addr_t a);
        if (a >= L2_INTLVD_START && a <= L2_INTLVD_END) begin
            return int'((a - L2_INTLVD_START) >> 2);
        end
        // Alias reaches the same words as the main window
        if (a >= L2_ALIAS_START && a <= L2_ALIAS_END) begin
            return int'((a - L2_ALIAS_START) >> 2);
        end
        if (a >= L2_PRIV_START && a <= L2_PRIV_END) begin
            return INTLVD_WORDS + int'((a - L2_PRIV_START) >> 2);
        end
        return -1;
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_rdata(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("mismatch %s: got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_err(input string name, input bit got, input bit exp);
        if (got !== exp) begin
            stop_with_error($sformatf("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_error($sformatf("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model and response checking
    ////////////////////////////////////////////////////////////

    // Applies an accepted request to the model and queues its expected answer
    task automatic record_transfer(input int m);
        int    loc;
        data_t word;
        loc = decode_loc(req_addr_i[m]);
        if (loc < 0) begin
            // Unmapped, memory untouched
            exp_rdata[m].push_back('0);
            exp_err[m].push_back(1'b1);
        end else if (req_we_i[m]) begin
            word = model_mem[loc];
            for (int b = 0; b < 4; b++) begin
                if (req_be_i[m][b]) begin
                    word[8*b +: 8] = req_wdata_i[m][8*b +: 8];
                end
            end
            model_mem[loc] = word;
            exp_rdata[m].push_back('0);
            exp_err[m].push_back(1'b0);
        end else begin
            exp_rdata[m].push_back(model_mem[loc]);
            exp_err[m].push_back(1'b0);
        end
    endtask

    task automatic check_response(input int m);
        data_t exp_d;
        bit    exp_e;
        if (exp_rdata[m].size() == 0) begin
            stop_with_error($sformatf("master %0d got a response with no request outstanding", m));
        end else begin
            exp_d = exp_rdata[m].pop_front();
            exp_e = exp_err[m].pop_front();
            check_rdata($sformatf("rsp_rdata_o[%0d]", m), rsp_rdata_o[m], exp_d);
            check_err($sformatf("rsp_err_o[%0d]", m), rsp_err_o[m], exp_e);
        end
    endtask

    // Outputs are settled mid cycle, transfers in master index order
    always @(negedge clk_i) begin
        if (arst_n_i) begin
            for (int m = 0; m < NUM_MASTERS; m++) begin
                if (req_valid_i[m] && req_ready_o[m]) begin
                    record_transfer(m);
                end
            end
            for (int m = 0; m < NUM_MASTERS; m++) begin
                if (rsp_valid_o[m] && rsp_ready_i[m]) begin
                    check_response(m);
                end
            end
        end
    end

    // Random low periods on the response ready lines
    always @(posedge clk_i) begin
        #1;
        for (int m = 0; m < NUM_MASTERS; m++) begin
            rdy_rng[m] = xorshift(rdy_rng[m]);
            if (stall_len[m] > 0) begin
                stall_len[m]--;
            end else if (stall_en && rdy_rng[m][3:0] == 4'd0) begin
                stall_len[m] = int'(rdy_rng[m][6:4]) + 1;
            end
            rsp_ready_i[m] = (stall_len[m] == 0);
        end
    end

    ////////////////////////////////////////////////////////////
    // Master drivers
    ////////////////////////////////////////////////////////////

    task automatic drive_master(input int m, input int n, input int mode);
        logic [31:0] st;
        int          sent;
        logic        busy;
        st   = SEED ^ {24'h0, 4'(mode), 4'(m + 1)};
        sent = 0;
        busy = 1'b0;
        while (sent < n) begin
            @(posedge clk_i);
            #1;
            if (!busy) begin
                st = xorshift(st);
                // Idle gap now and then in random mode
                if (mode == MODE_RANDOM && st[2:0] == 3'd0) begin
                    req_valid_i[m] = 1'b0;
                end else begin
                    st = xorshift(st);
                    if (mode == MODE_PRELOAD) begin
                        // Master 0 fills the interleaved pool, master 1 the private one
                        req_addr_i[m]  = (m == 0 ? L2_INTLVD_START : L2_PRIV_START) +
                                         addr_t'(sent * 4);
                        req_we_i[m]    = 1'b1;
                        req_be_i[m]    = 4'hf;
                        req_wdata_i[m] = st;
                    end else begin
                        req_addr_i[m]  = pick_addr(st);
                        st             = xorshift(st);
                        req_wdata_i[m] = st;
                        st             = xorshift(st);
                        req_we_i[m]    = st[0];
                        req_be_i[m]    = st[4:1];
                    end
                    req_valid_i[m] = 1'b1;
                    busy           = 1'b1;
                end
            end
            @(negedge clk_i);
            if (busy && req_ready_o[m]) begin
                busy = 1'b0;
                sent++;
            end
        end
        @(posedge clk_i);
        #1;
        req_valid_i[m] = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        #((TOTAL_REQS * 40 + 64) * CLK_PERIOD);
        stop_with_error("watchdog expired before all requests were answered");
    end

    initial begin
        int stray_master;
        stray_master = -1;
        arst_n_i = 1'b0;
        stall_en = 1'b0;
        for (int m = 0; m < NUM_MASTERS; m++) begin
            req_valid_i[m] = 1'b0;
            req_addr_i[m]  = '0;
            req_we_i[m]    = 1'b0;
            req_be_i[m]    = '0;
            req_wdata_i[m] = '0;
            rsp_ready_i[m] = 1'b1;
            rdy_rng[m]     = SEED ^ (32'h5a5a_0000 + 32'(m + 1));
            stall_len[m]   = 0;
        end
        repeat (16) @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;

        // Quiet bus after reset
        repeat (8) begin
            @(negedge clk_i);
            for (int m = 0; m < NUM_MASTERS; m++) begin
                check_flag($sformatf("req_ready_o[%0d]", m), req_ready_o[m], 1'b0);
                check_flag($sformatf("rsp_valid_o[%0d]", m), rsp_valid_o[m], 1'b0);
            end
        end

        // Known contents for every word the random phases touch
        fork
            drive_master(0, POOL_WORDS, MODE_PRELOAD);
            drive_master(1, POOL_WORDS, MODE_PRELOAD);
        join

        stall_en = 1'b1;
        fork
            drive_master(0, N_RANDOM, MODE_RANDOM);
            drive_master(1, N_RANDOM, MODE_RANDOM);
        join

        // Both masters always valid
        fork
            drive_master(0, N_SATURATE, MODE_SATURATE);
            drive_master(1, N_SATURATE, MODE_SATURATE);
        join

        while (exp_rdata[0].size() != 0 || exp_rdata[1].size() != 0) begin
            @(posedge clk_i);
        end

        // Every expectation is consumed, so any further valid is a duplicate response
        repeat (8) begin
            @(negedge clk_i);
            for (int m = 0; m < NUM_MASTERS; m++) begin
                if (rsp_valid_o[m] && stray_master < 0) begin
                    stray_master = m;
                end
            end
        end
        if (stray_master >= 0) begin
            stop_with_error($sformatf("master %0d got a response after all requests were answered",
                                      stray_master));
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

// File: soc_l2_interconnect.f
source/soc_mem_map_pkg.sv
source/l2_xbar_pkg.sv
source/l2_req_arbiter.sv
source/l2_req_fifo.sv
source/l2_bank_array.sv
source/soc_l2_interconnect.sv
test/tb_soc_l2_interconnect.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the L2 interconnect testbench with Verilator and runs it.
# The exit status is the simulator's: nonzero on any failure.

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_soc_l2_interconnect \
    -f soc_l2_interconnect.f \
    -Mdir obj_dir &&
./obj_dir/Vtb_soc_l2_interconnect || {
    echo "run_sim.sh: build or simulation returned an error" >&2
    exit 1
}
